// File: tb.f
+incdir+include
hw/md5_pkg.sv
hw/md5_pad.sv
hw/md5_sched.sv
hw/md5_step.sv
hw/md5_finish.sv
hw/md5_core.sv
sim/md5_tb.sv

// File: Makefile
# Verilator flow for the md5 core testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= md5_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --timing --assert
SIM_FLAGS  ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/md5_tb_model.svh
// -------------------------------------------------
// reference model for the md5 testbench
// pads one message into a block and computes its
// md5 digest in output byte order
// include inside a scope that imports md5_pkg
// -------------------------------------------------
`ifndef MD5_TB_MODEL_SVH
`define MD5_TB_MODEL_SVH

// msg holds max_bytes bytes in its low bits
// message byte 0 is the top one of those
function automatic block_t model_pad(input logic [8*55-1:0] msg,
                                     input int max_bytes,
                                     input int len);
   block_t blk;
   logic [63:0] bit_len;

   blk = '0;
   for (int n = 0; n < len; n++) begin
      blk[8*n +: 8] = msg[8*(max_bytes-1-n) +: 8];
   end
   blk[8*len +: 8] = 8'h80;
   // length in bits, least significant byte first
   bit_len = 64'(len) * 64'd8;
   for (int n = 0; n < 8; n++) begin
      blk[8*(56+n) +: 8] = bit_len[8*n +: 8];
   end
   return blk;
endfunction

function automatic word_t model_bswap(input word_t w);
   return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// plain md5 compression of one block
// constants come from sin() and not from the package tables
function automatic digest_t model_md5(input block_t blk);
   word_t a;
   word_t b;
   word_t c;
   word_t d;
   word_t f;
   word_t k;
   word_t tmp;
   word_t m [16];
   int    g;
   int    s;
   int    shifts [16];
   real   sv;

   shifts = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};
   for (int w = 0; w < 16; w++) begin
      m[w] = blk[32*w +: 32];
   end
   a = 32'h67452301;
   b = 32'hefcdab89;
   c = 32'h98badcfe;
   d = 32'h10325476;

   for (int i = 0; i < 64; i++) begin
      case (i / 16)
         0: begin
            f = (b & c) | (~b & d);
            g = i;
         end
         1: begin
            f = (b & d) | (c & ~d);
            g = (5 * i + 1) % 16;
         end
         2: begin
            f = b ^ c ^ d;
            g = (3 * i + 5) % 16;
         end
         default: begin
            f = c ^ (b | ~d);
            g = (7 * i) % 16;
         end
      endcase
      // floor(abs(sin(i + 1)) * 2^32)
      sv = $sin(real'(i + 1));
      if (sv < 0.0) begin
         sv = -sv;
      end
      k = word_t'(longint'($floor(sv * 4294967296.0)));
      tmp = a + f + k + m[g];
      s = shifts[(i / 16) * 4 + (i % 4)];
      tmp = (tmp << s) | (tmp >> (32 - s));
      a = d;
      d = c;
      c = b;
      b = b + tmp;
   end

   return {model_bswap(a + 32'h67452301), model_bswap(b + 32'hefcdab89),
           model_bswap(c + 32'h98badcfe), model_bswap(d + 32'h10325476)};
endfunction

// convenience wrapper used at every accept
function automatic digest_t model_digest(input logic [8*55-1:0] msg,
                                         input int max_bytes,
                                         input int len);
   return model_md5(model_pad(msg, max_bytes, len));
endfunction

`endif

// File: sim/md5_tb.sv
// -------------------------------------------------
// testbench for the single block md5 core
// drives messages on the falling edge and checks
// digest, latency, ready and digest hold with
// concurrent assertions against the include model
// -------------------------------------------------
`timescale 1ns/1ps

module md5_tb
   import md5_pkg::*;
();

`include "md5_tb_model.svh"

   localparam int MAX_MSG_BYTES = 16;
   localparam int NUM_RANDOM    = 40;
   localparam int NUM_BUSY      = 4;
   localparam int NUM_BACK      = 8;
   // accepted messages, empty plus 1..16 plus the rest
   localparam int NUM_MSGS = 1 + MAX_MSG_BYTES + NUM_RANDOM + NUM_BUSY + NUM_BACK;
   localparam int WATCHDOG_CYCLES = 16 + 200 * NUM_MSGS;
   localparam int unsigned SEED = 32'ha2703a51;

   logic                       clk;
   logic                       reset;
   logic                       start;
   logic [8*MAX_MSG_BYTES-1:0] msg;
   logic [5:0]                 msg_len;
   logic                       ready;
   digest_t                    digest;
   logic                       digest_valid;

   // model side
   logic [8*55-1:0] msg_wide;
   digest_t         exp_digest;
   digest_t         digest_prev;
   logic            seen;
   int              cyc;
   int              errors = 0;
   int              accepts = 0;
   int              valids = 0;

   md5_core #(
      .MAX_MSG_BYTES (MAX_MSG_BYTES)
   ) dut (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .msg          (msg),
      .msg_len      (msg_len),
      .ready        (ready),
      .digest       (digest),
      .digest_valid (digest_valid)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   assign msg_wide = (8*55)'(msg);

   // --------------------------------------------------
   // expected digest and edge count since accept
   // --------------------------------------------------
   // cyc holds k in the cycle after edge k, the accept edge is edge 1
   always @(posedge clk) begin
      digest_prev <= digest;
      if (reset) begin
         seen <= 1'b0;
         cyc  <= 1000;
      end else begin
         if (ready && start) begin
            exp_digest <= model_digest(msg_wide, MAX_MSG_BYTES, int'(msg_len));
            cyc        <= 1;
            seen       <= 1'b1;
            accepts    <= accepts + 1;
         end else if (cyc < 1000) begin
            cyc <= cyc + 1;
         end
         if (digest_valid) begin
            valids <= valids + 1;
         end
      end
   end

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   // idle levels before the first accept
   a_ready_after_reset: assert property (@(posedge clk) disable iff (reset)
      !seen |-> ready)
      else begin
         errors++;
         $display("ERROR: %0t ready expected 1 actual %b", $time, $sampled(ready));
      end

   a_valid_after_reset: assert property (@(posedge clk) disable iff (reset)
      !seen |-> !digest_valid)
      else begin
         errors++;
         $display("ERROR: %0t digest_valid expected 0 actual 1", $time);
      end

   // valid only 66 edges after accept, so one cycle wide
   a_valid_timing: assert property (@(posedge clk) disable iff (reset)
      digest_valid |-> seen && cyc == 66)
      else begin
         errors++;
         $display("ERROR: %0t digest_valid expected 0 actual 1 at %0d edges after accept",
                  $time, $sampled(cyc));
      end

   a_valid_due: assert property (@(posedge clk) disable iff (reset)
      seen && cyc == 66 |-> digest_valid)
      else begin
         errors++;
         $display("ERROR: %0t digest_valid expected 1 actual 0", $time);
      end

   // ready low from accept, back one edge after valid
   a_ready_busy: assert property (@(posedge clk) disable iff (reset)
      seen && cyc < 67 |-> !ready)
      else begin
         errors++;
         $display("ERROR: %0t ready expected 0 actual 1", $time);
      end

   a_ready_back: assert property (@(posedge clk) disable iff (reset)
      seen && cyc >= 67 |-> ready)
      else begin
         errors++;
         $display("ERROR: %0t ready expected 1 actual 0", $time);
      end

   a_digest_value: assert property (@(posedge clk) disable iff (reset)
      digest_valid |-> digest == exp_digest)
      else begin
         errors++;
         $display("ERROR: %0t digest expected %h actual %h",
                  $time, $sampled(exp_digest), $sampled(digest));
      end

   // digest may only move on the valid edge
   a_digest_hold: assert property (@(posedge clk) disable iff (reset)
      !digest_valid |-> digest == digest_prev)
      else begin
         errors++;
         $display("ERROR: %0t digest expected %h actual %h",
                  $time, $sampled(digest_prev), $sampled(digest));
      end

   // --------------------------------------------------
   // stimulus helpers
   // --------------------------------------------------
   function automatic logic [8*MAX_MSG_BYTES-1:0] random_msg();
      logic [8*MAX_MSG_BYTES-1:0] m;

      for (int i = 0; i < MAX_MSG_BYTES; i++) begin
         m[8*i +: 8] = 8'($urandom);
      end
      return m;
   endfunction

   function automatic logic [5:0] random_len();
      return 6'($urandom_range(0, MAX_MSG_BYTES));
   endfunction

   // waits for ready, then one start cycle
   task automatic send_msg(input logic [8*MAX_MSG_BYTES-1:0] m, input logic [5:0] len);
      @(negedge clk);
      while (!ready) begin
         @(negedge clk);
      end
      start   = 1'b1;
      msg     = m;
      msg_len = len;
      @(negedge clk);
      start = 1'b0;
   endtask

   task automatic wait_valid();
      @(negedge clk);
      while (!digest_valid) begin
         @(negedge clk);
      end
   endtask

   // start pulses and new data while busy, stops well before ready
   task automatic poke_while_busy();
      for (int i = 0; i < 60; i++) begin
         @(negedge clk);
         start   = 1'($urandom_range(0, 1));
         msg     = random_msg();
         msg_len = random_len();
      end
      @(negedge clk);
      start = 1'b0;
   endtask

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial begin
      void'($urandom(SEED));
      reset   = 1'b1;
      start   = 1'b0;
      msg     = '0;
      msg_len = '0;
      repeat (16) @(negedge clk);
      reset = 1'b0;
      // a few idle cycles after reset
      repeat (5) @(negedge clk);

      // empty message, then every length
      send_msg(random_msg(), 6'd0);
      wait_valid();
      for (int len = 1; len <= MAX_MSG_BYTES; len++) begin
         send_msg(random_msg(), 6'(len));
         wait_valid();
      end

      for (int i = 0; i < NUM_RANDOM; i++) begin
         send_msg(random_msg(), random_len());
         wait_valid();
      end

      for (int i = 0; i < NUM_BUSY; i++) begin
         send_msg(random_msg(), random_len());
         poke_while_busy();
         wait_valid();
      end

      // start again as soon as ready returns
      for (int i = 0; i < NUM_BACK; i++) begin
         send_msg(random_msg(), random_len());
      end
      wait_valid();
      repeat (4) @(negedge clk);

      if (accepts != NUM_MSGS) begin
         errors++;
         $display("the DUT accepted %0d messages where %0d were sent", accepts, NUM_MSGS);
      end
      if (valids != accepts) begin
         errors++;
         $display("%0d valid pulses seen for %0d accepted messages", valids, accepts);
      end
      $display("errors: %0d, messages: %0d, digests: %0d", errors, accepts, valids);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   // watchdog, sized from the message count
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: hw/md5_core.sv
// -------------------------------------------------
// md5 core top level
// single block digest of a message of up to
// MAX_MSG_BYTES bytes, start strobe taken while
// ready, digest_valid pulses once per message
// -------------------------------------------------
`timescale 1ns/1ps

module md5_core
   import md5_pkg::*;
#(
   // 0 to 55, must leave room for 0x80 and the length
   parameter int MAX_MSG_BYTES = 16
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       start,
   input  logic [8*MAX_MSG_BYTES-1:0] msg,
   input  logic [5:0]                 msg_len,
   output logic                       ready,
   output digest_t                    digest,
   output logic                       digest_valid
);

   logic       load;
   logic       step_en;
   logic       finish;
   step_ctrl_t ctrl;
   word_t      word;
   word_t      state_a;
   word_t      state_b;
   word_t      state_c;
   word_t      state_d;

   // --------------------------------------------------
   // control
   // --------------------------------------------------
   md5_sched u_sched (
      .clk     (clk),
      .reset   (reset),
      .start   (start),
      .ready   (ready),
      .load    (load),
      .step_en (step_en),
      .ctrl    (ctrl),
      .finish  (finish)
   );

   // --------------------------------------------------
   // datapath
   // --------------------------------------------------
   md5_pad #(
      .MAX_MSG_BYTES (MAX_MSG_BYTES)
   ) u_pad (
      .clk      (clk),
      .reset    (reset),
      .load     (load),
      .msg      (msg),
      .msg_len  (msg_len),
      .word_idx (ctrl.word_idx),
      .word     (word)
   );

   md5_step u_step (
      .clk     (clk),
      .reset   (reset),
      .load    (load),
      .step_en (step_en),
      .ctrl    (ctrl),
      .word    (word),
      .state_a (state_a),
      .state_b (state_b),
      .state_c (state_c),
      .state_d (state_d)
   );

   md5_finish u_finish (
      .clk          (clk),
      .reset        (reset),
      .finish       (finish),
      .state_a      (state_a),
      .state_b      (state_b),
      .state_c      (state_c),
      .state_d      (state_d),
      .digest       (digest),
      .digest_valid (digest_valid)
   );

endmodule

// File: hw/md5_finish.sv
// -------------------------------------------------
// md5 output stage
// adds the initial values to the final state,
// byte swaps each word into digest order and holds
// the digest with a one cycle valid pulse
// -------------------------------------------------
`timescale 1ns/1ps

module md5_finish
   import md5_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    finish,
   input  word_t   state_a,
   input  word_t   state_b,
   input  word_t   state_c,
   input  word_t   state_d,
   output digest_t digest,
   output logic    digest_valid
);

   word_t sum_a;
   word_t sum_b;
   word_t sum_c;
   word_t sum_d;

   // md5 words are little-endian in the digest
   function automatic word_t byte_swap(input word_t w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

   // single block so the chaining input is the iv
   assign sum_a = state_a + IV_A;
   assign sum_b = state_b + IV_B;
   assign sum_c = state_c + IV_C;
   assign sum_d = state_d + IV_D;

   // digest held until the next finish
   always_ff @(posedge clk) begin
      if (reset) begin
         digest       <= '0;
         digest_valid <= 1'b0;
      end else begin
         digest_valid <= finish;
         if (finish) begin
            digest <= {byte_swap(sum_a), byte_swap(sum_b),
                       byte_swap(sum_c), byte_swap(sum_d)};
         end
      end
   end

   // one pulse per block
   a_valid_pulse: assert property (
      @(posedge clk) disable iff (reset)
      digest_valid |=> !digest_valid
   );

endmodule

// File: hw/md5_step.sv
// -------------------------------------------------
// md5 step datapath
// working registers a to d with the four round
// functions, the add chain and the left rotate
// one step per enabled cycle
// -------------------------------------------------
`timescale 1ns/1ps

module md5_step
   import md5_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       load,
   input  logic       step_en,
   input  step_ctrl_t ctrl,
   input  word_t      word,
   output word_t      state_a,
   output word_t      state_b,
   output word_t      state_c,
   output word_t      state_d
);

   word_t       a_q;
   word_t       b_q;
   word_t       c_q;
   word_t       d_q;
   word_t       f;
   word_t       sum;
   logic [63:0] rot_wide;
   word_t       new_b;

   // --------------------------------------------------
   // round function
   // --------------------------------------------------
   always_comb begin
      unique case (ctrl.round)
         ROUND_F: f = (b_q & c_q) | (~b_q & d_q);
         ROUND_G: f = (b_q & d_q) | (c_q & ~d_q);
         ROUND_H: f = b_q ^ c_q ^ d_q;
         ROUND_I: f = c_q ^ (b_q | ~d_q);
         default: f = '0;
      endcase
   end

   // --------------------------------------------------
   // add chain and rotate
   // --------------------------------------------------
   // a + f + m + k, all mod 2^32
   assign sum = a_q + f + word + ctrl.k;

   // rotate left via a doubled word
   assign rot_wide = {sum, sum} << ctrl.shift;

   assign new_b = b_q + rot_wide[63:32];

   // --------------------------------------------------
   // working registers
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset || load) begin
         a_q <= IV_A;
         b_q <= IV_B;
         c_q <= IV_C;
         d_q <= IV_D;
      end else if (step_en) begin
         // usual rotation, new value lands in b
         a_q <= d_q;
         d_q <= c_q;
         c_q <= b_q;
         b_q <= new_b;
      end
   end

   assign state_a = a_q;
   assign state_b = b_q;
   assign state_c = c_q;
   assign state_d = d_q;

endmodule

// File: hw/md5_sched.sv
// -------------------------------------------------
// control FSM for one md5 block
// idle, 64 round steps, finish and one turn-around
// cycle, with the step counter that indexes the
// constant tables for the datapath
// -------------------------------------------------
`timescale 1ns/1ps

module md5_sched
   import md5_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       start,
   output logic       ready,
   output logic       load,
   output logic       step_en,
   output step_ctrl_t ctrl,
   output logic       finish
);

   sched_state_t state_q;
   sched_state_t state_d;
   step_idx_t    cnt_q;
   logic         last_step;

   // --------------------------------------------------
   // state machine
   // --------------------------------------------------
   assign last_step = (cnt_q == step_idx_t'(NUM_STEPS - 1));

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         IDLE: begin
            if (start) begin
               state_d = ROUNDS;
            end
         end
         ROUNDS: begin
            if (last_step) begin
               state_d = FINISH;
            end
         end
         // one cycle for the final add
         FINISH: state_d = TURN;
         // valid pulse goes out here
         TURN: state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // step counter wraps back to zero after step 63
   always_ff @(posedge clk) begin
      if (reset) begin
         cnt_q <= '0;
      end else if (step_en) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // --------------------------------------------------
   // strobes and levels
   // --------------------------------------------------
   assign ready   = (state_q == IDLE);
   // start is only taken while ready
   assign load    = ready && start;
   assign step_en = (state_q == ROUNDS);
   assign finish  = (state_q == FINISH);

   // per-step control from the package tables
   always_comb begin
      ctrl.round    = round_t'(cnt_q[5:4]);
      ctrl.word_idx = STEP_WORD[cnt_q];
      ctrl.shift    = STEP_SHIFT[{cnt_q[5:4], cnt_q[1:0]}];
      ctrl.k        = STEP_CONST[cnt_q];
   end

   // counter has to be back at zero between blocks
   a_idle_cnt_zero: assert property (
      @(posedge clk) disable iff (reset)
      (state_q == IDLE) |-> (cnt_q == '0)
   );

   // a block runs exactly 64 step cycles
   a_step_len: assert property (
      @(posedge clk) disable iff (reset)
      $fell(step_en) |-> $past(step_en, NUM_STEPS) && !$past(step_en, NUM_STEPS + 1)
   );

endmodule

// File: hw/md5_pad.sv
// -------------------------------------------------
// message padding and block storage
// latches the padded block on load and serves the
// message word picked by the scheduler each step
// -------------------------------------------------
`timescale 1ns/1ps

module md5_pad
   import md5_pkg::*;
#(
   parameter int MAX_MSG_BYTES = 16
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       load,
   input  logic [8*MAX_MSG_BYTES-1:0] msg,
   input  logic [5:0]                 msg_len,
   input  word_idx_t                  word_idx,
   output word_t                      word
);

   // byte n of the block sits at bits [8n +: 8]
   // so each 32-bit slice reads little-endian
   block_t padded;
   block_t block_q;

   // --------------------------------------------------
   // padding
   // --------------------------------------------------
   always_comb begin
      padded = '0;
      // message bytes first, msg byte 0 is the top byte
      for (int n = 0; n < MAX_MSG_BYTES; n++) begin
         if (n < int'(msg_len)) begin
            padded[8*n +: 8] = msg[8*(MAX_MSG_BYTES-1-n) +: 8];
         end
      end
      // single 1 bit right after the message
      padded[8*msg_len +: 8] = 8'h80;
      // bit length in bytes 56 to 63, lsb first
      padded[448 +: 64] = 64'(msg_len) << 3;
   end

   // padded block, loaded at accept
   always_ff @(posedge clk) begin
      if (load) begin
         block_q <= padded;
      end
   end

   // word select for the current step
   assign word = block_q[{word_idx, 5'b0} +: 32];

   // length must fit the message port
   a_len_fits: assert property (
      @(posedge clk) disable iff (reset)
      load |-> (int'(msg_len) <= MAX_MSG_BYTES)
   );

endmodule

// File: hw/md5_pkg.sv
// -------------------------------------------------
// shared types and constant tables for the md5 core
// word, block and digest widths, step control
// bundle, initial chaining values and the per-step
// sine constant, shift and message word tables
// -------------------------------------------------
package md5_pkg;

   // widths with a meaning
   typedef logic [31:0]  word_t;
   typedef logic [511:0] block_t;
   typedef logic [127:0] digest_t;
   typedef logic [5:0]   step_idx_t;
   typedef logic [3:0]   word_idx_t;
   typedef logic [4:0]   shift_t;

   // round function select, one round per 16 steps
   typedef enum logic [1:0] {
      ROUND_F,
      ROUND_G,
      ROUND_H,
      ROUND_I
   } round_t;

   // control flow of one block
   typedef enum logic [1:0] {
      IDLE,
      ROUNDS,
      FINISH,
      TURN
   } sched_state_t;

   // everything the datapath needs for one step
   typedef struct packed {
      round_t    round;
      word_idx_t word_idx;
      shift_t    shift;
      word_t     k;
   } step_ctrl_t;

   localparam int NUM_STEPS = 64;

   // --------------------------------------------------
   // initial chaining values
   // --------------------------------------------------
   localparam word_t IV_A = 32'h67452301;
   localparam word_t IV_B = 32'hefcdab89;
   localparam word_t IV_C = 32'h98badcfe;
   localparam word_t IV_D = 32'h10325476;

   // --------------------------------------------------
   // per-step tables
   // --------------------------------------------------
   // floor(abs(sin(i + 1)) * 2^32)
   localparam word_t STEP_CONST [0:63] = '{
      32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
      32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
      32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
      32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
      32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
      32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
      32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
      32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
      32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
      32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
      32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
      32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
      32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
      32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
      32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
      32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
   };

   // indexed by {round, step[1:0]}
   localparam shift_t STEP_SHIFT [0:15] = '{
      5'd7, 5'd12, 5'd17, 5'd22,
      5'd5, 5'd9,  5'd14, 5'd20,
      5'd4, 5'd11, 5'd16, 5'd23,
      5'd6, 5'd10, 5'd15, 5'd21
   };

   // word order per round
   // i, 5i+1, 3i+5 and 7i, all mod 16
   localparam word_idx_t STEP_WORD [0:63] = '{
      4'd0,  4'd1,  4'd2,  4'd3,  4'd4,  4'd5,  4'd6,  4'd7,
      4'd8,  4'd9,  4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15,
      4'd1,  4'd6,  4'd11, 4'd0,  4'd5,  4'd10, 4'd15, 4'd4,
      4'd9,  4'd14, 4'd3,  4'd8,  4'd13, 4'd2,  4'd7,  4'd12,
      4'd5,  4'd8,  4'd11, 4'd14, 4'd1,  4'd4,  4'd7,  4'd10,
      4'd13, 4'd0,  4'd3,  4'd6,  4'd9,  4'd12, 4'd15, 4'd2,
      4'd0,  4'd7,  4'd14, 4'd5,  4'd12, 4'd3,  4'd10, 4'd1,
      4'd8,  4'd15, 4'd6,  4'd13, 4'd4,  4'd11, 4'd2,  4'd9
   };

endpackage
